// ==== Bender.yml ====
package:
  name: axis_frame_fifo_cdc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/frame_fifo_pkg.sv
      - rtl/frame_write_ctrl.sv
      - rtl/gray_ptr_sync.sv
      - rtl/frame_ram.sv
      - rtl/frame_read_ctrl.sv
      - rtl/axis_frame_fifo_cdc.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/frame_fifo_props.sv
      - verification/frame_fifo_tb.sv

// ==== filelist.f ====
+incdir+rtl
rtl/frame_fifo_pkg.sv
rtl/frame_write_ctrl.sv
rtl/gray_ptr_sync.sv
rtl/frame_ram.sv
rtl/frame_read_ctrl.sv
rtl/axis_frame_fifo_cdc.sv
verification/tb_clk_gen.sv
verification/frame_fifo_props.sv
verification/frame_fifo_tb.sv

// ==== rtl/axis_frame_fifo_cdc.sv ====
// Dual clock AXI4-Stream frame FIFO that releases only whole good frames
`timescale 1ns/1ps
`include "frame_fifo_cfg.svh"

module axis_frame_fifo_cdc (
    input  logic                  input_clk,
    input  logic                  output_clk,
    input  logic                  output_rst_sync2,
    input  frame_fifo_pkg::data_t in_tdata,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    output frame_fifo_pkg::data_t out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic                  overflow,
    output logic                  bad_frame,
    output logic                  good_frame
);

    logic                          wr_en;
    logic [`FIFO_ADDR_WIDTH-1:0]   wr_addr;
    frame_fifo_pkg::mem_entry_t    wr_entry;
    frame_fifo_pkg::ptr_t          wr_ptr_commit;
    frame_fifo_pkg::gray_ptr_t     wr_gray_sync;
    logic                          rd_en;
    logic [`FIFO_ADDR_WIDTH-1:0]   rd_addr;
    frame_fifo_pkg::mem_entry_t    rd_entry;
    frame_fifo_pkg::ptr_t          rd_ptr;
    frame_fifo_pkg::gray_ptr_t     rd_gray_sync;

    frame_write_ctrl u_frame_write_ctrl (
        .input_clk        (input_clk),
        .output_rst_sync2 (output_rst_sync2),
        .in_tdata         (in_tdata),
        .in_tvalid        (in_tvalid),
        .in_tlast         (in_tlast),
        .in_tuser         (in_tuser),
        .in_tready        (in_tready),
        .rd_gray_sync     (rd_gray_sync),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_entry         (wr_entry),
        .wr_ptr_commit    (wr_ptr_commit),
        .overflow         (overflow),
        .bad_frame        (bad_frame),
        .good_frame       (good_frame)
    );

    frame_ram u_frame_ram (
        .input_clk  (input_clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_entry   (wr_entry),
        .output_clk (output_clk),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_entry   (rd_entry)
    );

    // committed write pointer into the output domain
    gray_ptr_sync u_wr_ptr_sync (
        .src_clk   (input_clk),
        .src_rst   (output_rst_sync2),
        .dst_clk   (output_clk),
        .dst_rst   (output_rst_sync2),
        .ptr       (wr_ptr_commit),
        .gray_sync (wr_gray_sync)
    );

    // read pointer back into the input domain for the full check
    gray_ptr_sync u_rd_ptr_sync (
        .src_clk   (output_clk),
        .src_rst   (output_rst_sync2),
        .dst_clk   (input_clk),
        .dst_rst   (output_rst_sync2),
        .ptr       (rd_ptr),
        .gray_sync (rd_gray_sync)
    );

    frame_read_ctrl u_frame_read_ctrl (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .wr_gray_sync     (wr_gray_sync),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_ptr           (rd_ptr),
        .rd_entry         (rd_entry),
        .out_tdata        (out_tdata),
        .out_tvalid       (out_tvalid),
        .out_tlast        (out_tlast),
        .out_tready       (out_tready)
    );

endmodule

// ==== rtl/frame_fifo_cfg.svh ====
// Configuration macros for the dual clock frame FIFO
`ifndef FRAME_FIFO_CFG_SVH
`define FRAME_FIFO_CFG_SVH

// memory address width, 16 entries
`define FIFO_ADDR_WIDTH 4

// tdata byte lane
`define FIFO_DATA_WIDTH 8

// flops per pointer crossing
`define FIFO_SYNC_STAGES 2

`endif

// ==== rtl/frame_fifo_pkg.sv ====
// Shared types of the frame FIFO for pointers, stored beats and the reader stage
`include "frame_fifo_cfg.svh"

package frame_fifo_pkg;

    // binary pointer with the wrap bit above the address
    typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;

    // same pointer in gray code for the crossings
    typedef logic [`FIFO_ADDR_WIDTH:0] gray_ptr_t;

    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

    // tlast in the top bit, byte below it
    typedef logic [`FIFO_DATA_WIDTH:0] mem_entry_t;

    // output register stage of the reader
    typedef enum logic {
        idle,
        holding
    } rd_state_e;

endpackage

// ==== rtl/frame_ram.sv ====
// Simple dual port frame memory with a registered read on the output clock
`timescale 1ns/1ps
`include "frame_fifo_cfg.svh"

module frame_ram (
    input  logic                        input_clk,
    input  logic                        wr_en,
    input  logic [`FIFO_ADDR_WIDTH-1:0] wr_addr,
    input  frame_fifo_pkg::mem_entry_t  wr_entry,
    input  logic                        output_clk,
    input  logic                        rd_en,
    input  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
    output frame_fifo_pkg::mem_entry_t  rd_entry
);

    frame_fifo_pkg::mem_entry_t mem [1 << `FIFO_ADDR_WIDTH];

    always_ff @(posedge input_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // read word holds between reads and doubles as the output data register
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            rd_entry <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/frame_read_ctrl.sv ====
// Output side frame reader with empty detection and the output register stage
`timescale 1ns/1ps
`include "frame_fifo_cfg.svh"

module frame_read_ctrl (
    input  logic                        output_clk,
    input  logic                        output_rst_sync2,
    input  frame_fifo_pkg::gray_ptr_t   wr_gray_sync,
    output logic                        rd_en,
    output logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
    output frame_fifo_pkg::ptr_t        rd_ptr,
    input  frame_fifo_pkg::mem_entry_t  rd_entry,
    output frame_fifo_pkg::data_t       out_tdata,
    output logic                        out_tvalid,
    output logic                        out_tlast,
    input  logic                        out_tready
);

    frame_fifo_pkg::rd_state_e state;
    frame_fifo_pkg::gray_ptr_t rd_gray;
    logic                      empty;
    logic                      stage_free;

    // only committed frames are visible through the write pointer crossing
    assign rd_gray = rd_ptr ^ (rd_ptr >> 1);
    assign empty   = rd_gray == wr_gray_sync;

    // refill in the same cycle a beat leaves
    assign stage_free = (state == frame_fifo_pkg::idle) | out_tready;
    assign rd_en      = stage_free & ~empty;
    assign rd_addr    = rd_ptr[`FIFO_ADDR_WIDTH-1:0];

    assign out_tvalid = state == frame_fifo_pkg::holding;
    assign out_tdata  = rd_entry[`FIFO_DATA_WIDTH-1:0];
    assign out_tlast  = rd_entry[`FIFO_DATA_WIDTH];

    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            state  <= frame_fifo_pkg::idle;
            rd_ptr <= '0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (stage_free) begin
                state <= empty ? frame_fifo_pkg::idle : frame_fifo_pkg::holding;
            end
        end
    end

endmodule

// ==== rtl/frame_write_ctrl.sv ====
// Input side frame writer that stores beats and commits only whole good frames
`timescale 1ns/1ps
`include "frame_fifo_cfg.svh"

module frame_write_ctrl (
    input  logic                              input_clk,
    input  logic                              output_rst_sync2,
    input  frame_fifo_pkg::data_t             in_tdata,
    input  logic                              in_tvalid,
    input  logic                              in_tlast,
    input  logic                              in_tuser,
    output logic                              in_tready,
    input  frame_fifo_pkg::gray_ptr_t         rd_gray_sync,
    output logic                              wr_en,
    output logic [`FIFO_ADDR_WIDTH-1:0]       wr_addr,
    output frame_fifo_pkg::mem_entry_t        wr_entry,
    output frame_fifo_pkg::ptr_t              wr_ptr_commit,
    output logic                              overflow,
    output logic                              bad_frame,
    output logic                              good_frame
);

    logic                      in_rst_meta;
    logic                      in_rst;
    logic                      wr_active;
    logic                      drop_frame;
    logic                      full;
    logic                      full_cur;
    logic                      discard;
    logic                      accept;
    frame_fifo_pkg::ptr_t      wr_ptr_cur;
    frame_fifo_pkg::gray_ptr_t wr_gray_cur;

    // input domain reset, asserts at once and releases after two input_clk edges
    always_ff @(posedge input_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            in_rst_meta <= 1'b1;
            in_rst      <= 1'b1;
        end else begin
            in_rst_meta <= 1'b0;
            in_rst      <= in_rst_meta;
        end
    end

    assign wr_gray_cur = wr_ptr_cur ^ (wr_ptr_cur >> 1);

    // full in gray code when the top two bits differ and the rest match
    assign full = wr_gray_cur == {~rd_gray_sync[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                                  rd_gray_sync[`FIFO_ADDR_WIDTH-2:0]};

    // current frame alone already fills the whole memory
    assign full_cur = wr_ptr_cur == {~wr_ptr_commit[`FIFO_ADDR_WIDTH],
                                     wr_ptr_commit[`FIFO_ADDR_WIDTH-1:0]};

    assign discard = full_cur | drop_frame;

    // an oversized frame keeps flowing so that it can be dropped at its end
    assign in_tready = wr_active & (~full | discard);
    assign accept    = in_tvalid & in_tready;

    assign wr_en    = accept & ~discard;
    assign wr_addr  = wr_ptr_cur[`FIFO_ADDR_WIDTH-1:0];
    assign wr_entry = {in_tlast, in_tdata};

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            wr_active     <= 1'b0;
            wr_ptr_cur    <= '0;
            wr_ptr_commit <= '0;
            drop_frame    <= 1'b0;
            overflow      <= 1'b0;
            bad_frame     <= 1'b0;
            good_frame    <= 1'b0;
        end else begin
            wr_active  <= 1'b1;
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;
            if (accept) begin
                if (discard) begin
                    // swallow the rest of the frame, rewind on its last beat
                    drop_frame <= ~in_tlast;
                    if (in_tlast) begin
                        wr_ptr_cur <= wr_ptr_commit;
                        overflow   <= 1'b1;
                    end
                end else if (in_tlast && in_tuser) begin
                    wr_ptr_cur <= wr_ptr_commit;
                    bad_frame  <= 1'b1;
                end else if (in_tlast) begin
                    wr_ptr_cur    <= wr_ptr_cur + 1'b1;
                    wr_ptr_commit <= wr_ptr_cur + 1'b1;
                    good_frame    <= 1'b1;
                end else begin
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/gray_ptr_sync.sv ====
// Gray code pointer crossing from a source clock into a destination clock
`timescale 1ns/1ps
`include "frame_fifo_cfg.svh"

module gray_ptr_sync (
    input  logic                      src_clk,
    input  logic                      src_rst,
    input  logic                      dst_clk,
    input  logic                      dst_rst,
    input  frame_fifo_pkg::ptr_t      ptr,
    output frame_fifo_pkg::gray_ptr_t gray_sync
);

    frame_fifo_pkg::gray_ptr_t gray_reg;
    frame_fifo_pkg::gray_ptr_t sync_reg [`FIFO_SYNC_STAGES];

    // registered in the source domain so no glitch reaches the first sync flop
    always_ff @(posedge src_clk or posedge src_rst) begin
        if (src_rst) begin
            gray_reg <= '0;
        end else begin
            gray_reg <= ptr ^ (ptr >> 1);
        end
    end

    always_ff @(posedge dst_clk or posedge dst_rst) begin
        if (dst_rst) begin
            for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
                sync_reg[i] <= '0;
            end
        end else begin
            sync_reg[0] <= gray_reg;
            for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
                sync_reg[i] <= sync_reg[i-1];
            end
        end
    end

    assign gray_sync = sync_reg[`FIFO_SYNC_STAGES-1];

endmodule

// ==== verification/frame_fifo_input.txt ====
// header: [13:12] outcome 0 good 1 bad 2 overflow, [8] tuser on last beat, [7:0] beat count
// followed by one word per beat with the tdata byte in [7:0]
0001 00a5
0004 0010 0011 0012 0013
0010 0020 0021 0022 0023 0024 0025 0026 0027
     0028 0029 002a 002b 002c 002d 002e 002f
1103 0030 0031 0032
0002 0040 0041
2014 0050 0051 0052 0053 0054 0055 0056 0057 0058 0059
     005a 005b 005c 005d 005e 005f 0060 0061 0062 0063
0005 0070 0071 0072 0073 0074
1101 0080
0003 0090 0091 0092

// ==== verification/frame_fifo_props.sv ====
// Bound assertions on the stream handshakes and the frame status pulses
`timescale 1ns/1ps

module frame_fifo_props (
    input logic                  input_clk,
    input logic                  output_clk,
    input logic                  output_rst_sync2,
    input logic                  in_tvalid,
    input logic                  in_tready,
    input logic                  in_tlast,
    input frame_fifo_pkg::data_t out_tdata,
    input logic                  out_tvalid,
    input logic                  out_tready,
    input logic                  out_tlast,
    input logic                  overflow,
    input logic                  bad_frame,
    input logic                  good_frame
);

    int fail_count = 0;

    // a stalled beat keeps valid, data and last
    out_hold_a: assert property (@(posedge output_clk) disable iff (output_rst_sync2)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
    else begin
        fail_count++;
        $error("output beat changed before it was taken");
    end

    out_reset_a: assert property (@(posedge output_clk) output_rst_sync2 |-> !out_tvalid)
    else begin
        fail_count++;
        $error("out_tvalid high during reset");
    end

    status_after_last_a: assert property (@(posedge input_clk) disable iff (output_rst_sync2)
        (overflow || bad_frame || good_frame) |-> $past(in_tvalid && in_tready && in_tlast))
    else begin
        fail_count++;
        $error("status pulse without an accepted last beat");
    end

endmodule

bind axis_frame_fifo_cdc frame_fifo_props u_frame_fifo_props (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync2 (output_rst_sync2),
    .in_tvalid        (in_tvalid),
    .in_tready        (in_tready),
    .in_tlast         (in_tlast),
    .out_tdata        (out_tdata),
    .out_tvalid       (out_tvalid),
    .out_tready       (out_tready),
    .out_tlast        (out_tlast),
    .overflow         (overflow),
    .bad_frame        (bad_frame),
    .good_frame       (good_frame)
);

// ==== verification/frame_fifo_tb.sv ====
// Testbench for the dual clock frame FIFO driven by frame records from a data file
`timescale 1ns/1ps

module frame_fifo_tb;

    logic                       input_clk;
    logic                       output_clk;
    logic                       output_rst_sync2;
    frame_fifo_pkg::data_t      in_tdata;
    logic                       in_tvalid;
    logic                       in_tready;
    logic                       in_tlast;
    logic                       in_tuser;
    frame_fifo_pkg::data_t      out_tdata;
    logic                       out_tvalid;
    logic                       out_tready;
    logic                       out_tlast;
    logic                       overflow;
    logic                       bad_frame;
    logic                       good_frame;

    logic [15:0]                stim_mem [0:255];
    logic [9:0]                 send_q [$];
    frame_fifo_pkg::mem_entry_t exp_q [$];
    frame_fifo_pkg::mem_entry_t exp_beat;
    logic [1:0]                 status_q [$];
    logic [1:0]                 exp_status;
    logic [31:0]                lfsr = 32'h9cb8;
    logic                       hold_off = 1'b1;
    logic                       seen_good = 1'b0;
    logic                       stim_loaded = 1'b0;
    int                         total_beats = 0;
    int                         accepted_beats = 0;
    int                         data_errors = 0;
    int                         flag_errors = 0;
    int                         other_errors = 0;
    int                         assert_errors = 0;

    tb_clk_gen #(.period_ns(20.0)) u_out_clk_gen (.clk(output_clk));
    tb_clk_gen #(.period_ns(14.0)) u_in_clk_gen (.clk(input_clk));

    axis_frame_fifo_cdc u_axis_frame_fifo_cdc (
        .input_clk        (input_clk),
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .in_tdata         (in_tdata),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .in_tlast         (in_tlast),
        .in_tuser         (in_tuser),
        .out_tdata        (out_tdata),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tlast        (out_tlast),
        .overflow         (overflow),
        .bad_frame        (bad_frame),
        .good_frame       (good_frame)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic check_data(input frame_fifo_pkg::data_t act,
                              input frame_fifo_pkg::data_t exp, input string what);
        if (act !== exp) begin
            data_errors++;
            $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            flag_errors++;
            $display("** Error @ %0t ns: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    // header word, then one word per beat
    task automatic load_stimulus();
        int          idx;
        int          len;
        int          i;
        logic [15:0] hdr;
        idx = 0;
        $readmemh("verification/frame_fifo_input.txt", stim_mem);
        hdr = stim_mem[0];
        while (!$isunknown(hdr) && hdr[7:0] != 8'd0) begin
            len = hdr[7:0];
            status_q.push_back(hdr[13:12]);
            for (i = 0; i < len; i++) begin
                send_q.push_back({hdr[8] && (i == len - 1), i == len - 1,
                                  stim_mem[idx + 1 + i][7:0]});
                if (hdr[13:12] == 2'd0) begin
                    exp_q.push_back({i == len - 1, stim_mem[idx + 1 + i][7:0]});
                end
            end
            total_beats += len;
            idx += len + 1;
            hdr = stim_mem[idx];
        end
        stim_loaded = 1'b1;
    endtask

    task automatic send_frames();
        logic [9:0] beat;
        while (send_q.size() != 0) begin
            beat = send_q.pop_front();
            @(negedge input_clk);
            in_tvalid = 1'b1;
            in_tuser  = beat[9];
            in_tlast  = beat[8];
            in_tdata  = beat[7:0];
            @(posedge input_clk);
            while (!in_tready) begin
                @(posedge input_clk);
            end
            accepted_beats++;
        end
        @(negedge input_clk);
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tuser  = 1'b0;
    endtask

    // output held off until the memory has filled up
    task automatic release_hold();
        wait (accepted_beats >= 16);
        repeat (10) @(negedge input_clk);
        check_flag(in_tready, 1'b0, "in_tready with the memory full");
        @(posedge output_clk);
        hold_off = 1'b0;
    endtask

    always @(negedge output_clk) begin
        lfsr       = lfsr_step(lfsr);
        out_tready = ~hold_off & lfsr[0];
    end

    always @(posedge input_clk) begin
        if (overflow || bad_frame || good_frame) begin
            if (status_q.size() == 0) begin
                other_errors++;
                $display("status pulse at %0t ns with no frame outstanding", $time);
            end else begin
                exp_status = status_q.pop_front();
                check_flag(good_frame, exp_status == 2'd0, "good_frame");
                check_flag(bad_frame, exp_status == 2'd1, "bad_frame");
                check_flag(overflow, exp_status == 2'd2, "overflow");
            end
            if (good_frame) begin
                seen_good = 1'b1;
            end
        end
    end

    always @(posedge output_clk) begin
        if (out_tvalid && !seen_good) begin
            other_errors++;
            $display("out_tvalid high at %0t ns before any frame was committed", $time);
        end
        if (out_tvalid && out_tready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("extra output beat %h at %0t ns", out_tdata, $time);
            end else begin
                exp_beat = exp_q.pop_front();
                check_data(out_tdata, exp_beat[7:0], "out_tdata");
                check_flag(out_tlast, exp_beat[8], "out_tlast");
            end
        end
    end

    initial begin
        wait (stim_loaded);
        #((total_beats + 40) * 400);
        $display("watchdog expired at %0t ns with %0d beats and %0d status pulses missing",
                 $time, exp_q.size(), status_q.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        output_rst_sync2 = 1'b1;
        in_tdata         = '0;
        in_tvalid        = 1'b0;
        in_tlast         = 1'b0;
        in_tuser         = 1'b0;
        out_tready       = 1'b0;
        load_stimulus();
        repeat (5) @(posedge output_clk);
        @(negedge output_clk);
        output_rst_sync2 = 1'b0;
        fork
            send_frames();
            release_hold();
        join
        while (exp_q.size() != 0 || status_q.size() != 0) begin
            @(posedge output_clk);
        end
        // a duplicated beat would show up here
        repeat (20) @(posedge output_clk);
        check_flag(out_tvalid, 1'b0, "out_tvalid after the last frame");
        assert_errors = u_axis_frame_fifo_cdc.u_frame_fifo_props.fail_count;
        $display("errors: data %0d, flag %0d, other %0d, assertion %0d",
                 data_errors, flag_errors, other_errors, assert_errors);
        if (data_errors + flag_errors + other_errors + assert_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clk_gen.sv ====
// Free running testbench clock source with a settable period
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period_ns / 2.0);
        clk = ~clk;
    end

endmodule
